/* verilog/decodePkg.sv */
/*
	Shared definitions for the micro-op decode stage.
	Holds the micro-op field widths and bit positions, together with the
	opcode, function, unit and operand size encodings. Modules pull these
	in with a wildcard import in their body and use scoped names on ports.
*/

`default_nettype none

package decodePkg;

	// ==================================================
	// Widths
	// ==================================================

	// Whole micro-op word
	localparam int INSTR_W = 32;
	// Register number, 64 architectural registers
	localparam int REG_W = 6;
	// Raw immediate as carried in the micro-op
	localparam int IMM_W = 13;
	// Immediate after sign extension to the datapath width
	localparam int DATA_W = 64;
	// Opcode and function fields are both seven bits
	localparam int OPC_W = 7;
	localparam int FUNC_W = 7;

	// ==================================================
	// Field positions, given as the low bit of each field
	// ==================================================

	localparam int OPC_LSB = 0;
	localparam int RD_LSB = 7;
	localparam int RS1_LSB = 13;
	localparam int RS2_LSB = 19;
	// The immediate overlaps rs2 and func in the immediate forms
	localparam int IMM_LSB = 19;
	localparam int FUNC_LSB = 25;

	// ==================================================
	// Encodings
	// ==================================================

	// Major opcode in bits 6 to 0
	typedef enum logic [OPC_W-1:0] {
		OP_R3B   = 7'h02,
		OP_R3W   = 7'h03,
		OP_R3T   = 7'h04,
		OP_R3O   = 7'h05,
		// Paired register form, always octa sized
		OP_R3P   = 7'h06,
		OP_ADDI  = 7'h10,
		OP_MULI  = 7'h11,
		OP_DIVI  = 7'h13,
		OP_LOAD  = 7'h20,
		OP_STORE = 7'h21
	} opcode_e;

	// Function code in bits 31 to 25, only looked at for R3 opcodes
	typedef enum logic [FUNC_W-1:0] {
		FN_ADD = 7'h04,
		FN_SUB = 7'h05,
		FN_AND = 7'h08,
		FN_OR  = 7'h09,
		FN_MUL = 7'h10,
		FN_DIV = 7'h11,
		FN_REM = 7'h12
	} func_e;

	// Functional unit chosen by the classifier
	typedef enum logic [2:0] {
		UNIT_NONE = 3'd0,
		UNIT_ALU  = 3'd1,
		UNIT_MUL  = 3'd2,
		UNIT_DIV  = 3'd3,
		UNIT_MEM  = 3'd4
	} unit_e;

	// Operand size, from one byte up to an octa of eight bytes
	typedef enum logic [1:0] {
		SZ_BYTE  = 2'd0,
		SZ_WYDE  = 2'd1,
		SZ_TETRA = 2'd2,
		SZ_OCTA  = 2'd3
	} size_e;

endpackage

`default_nettype wire

/* verilog/decodeUnitClass.sv */
/*
	Functional unit classifier for one micro-op.
	Purely combinational. Looks at the opcode and, for register forms, the
	function field, then names the unit that executes the micro-op. Any
	encoding it does not know is reported as illegal with no unit.
*/

`timescale 1ns/100ps
`default_nettype none

module decodeUnitClass (
	input  wire logic [decodePkg::INSTR_W-1:0] instr,
	output decodePkg::unit_e                   unit,
	output logic                               illegal
);

	import decodePkg::*;

	opcode_e opcode;
	func_e   func;

	// Pull the two fields that matter for classification
	assign opcode = opcode_e'(instr[OPC_LSB +: OPC_W]);
	assign func   = func_e'(instr[FUNC_LSB +: FUNC_W]);

	// True for every register-register opcode, the paired form included
	function automatic logic fnIsR3(input opcode_e op);
		fnIsR3 = op == OP_R3B || op == OP_R3W || op == OP_R3T ||
			op == OP_R3O || op == OP_R3P;
	endfunction

	// Divide recognition
	// Remainder runs on the divider too, so it counts as a divide
	function automatic logic fnIsDivs(input opcode_e op, input func_e fn);
		fnIsDivs = op == OP_DIVI ||
			(fnIsR3(op) && (fn == FN_DIV || fn == FN_REM));
	endfunction

	function automatic logic fnIsMuls(input opcode_e op, input func_e fn);
		fnIsMuls = op == OP_MULI || (fnIsR3(op) && fn == FN_MUL);
	endfunction

	// Simple integer work for the ALU
	function automatic logic fnIsAlu(input opcode_e op, input func_e fn);
		fnIsAlu = op == OP_ADDI || (fnIsR3(op) &&
			(fn == FN_ADD || fn == FN_SUB || fn == FN_AND || fn == FN_OR));
	endfunction

	// ==================================================
	// Unit selection
	// ==================================================

	always_comb
	begin
		unit    = UNIT_NONE;
		illegal = 1'b0;
		if (fnIsDivs(opcode, func))
			unit = UNIT_DIV;
		else if (fnIsMuls(opcode, func))
			unit = UNIT_MUL;
		else if (opcode == OP_LOAD || opcode == OP_STORE)
			unit = UNIT_MEM;
		else if (fnIsAlu(opcode, func))
			unit = UNIT_ALU;
		else
		begin
			// Unknown opcode, or an R3 opcode carrying an unlisted func
			illegal = 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verilog/decodeOperands.sv */
/*
	Operand field decoder for one micro-op.
	Purely combinational. Slices out the register numbers, sign extends the
	immediate and works out the operand size and whether rd gets written.
	Legality is left to the unit classifier.
*/

`timescale 1ns/100ps
`default_nettype none

module decodeOperands (
	input  wire logic [decodePkg::INSTR_W-1:0] instr,
	output logic [decodePkg::REG_W-1:0]        rd,
	output logic [decodePkg::REG_W-1:0]        rs1,
	output logic [decodePkg::REG_W-1:0]        rs2,
	output logic [decodePkg::DATA_W-1:0]       imm,
	output logic                               useImm,
	output decodePkg::size_e                   size,
	output logic                               writesRd
);

	import decodePkg::*;

	opcode_e opcode;
	logic    immSign;

	assign opcode = opcode_e'(instr[OPC_LSB +: OPC_W]);

	// ==================================================
	// Register fields
	// ==================================================

	// These sit at fixed positions in every format
	assign rd  = instr[RD_LSB +: REG_W];
	assign rs1 = instr[RS1_LSB +: REG_W];
	assign rs2 = instr[RS2_LSB +: REG_W];

	// ==================================================
	// Immediate
	// ==================================================

	// Top bit of the raw immediate, copied up to fill the datapath width
	assign immSign = instr[IMM_LSB + IMM_W - 1];
	assign imm = {{(DATA_W - IMM_W){immSign}}, instr[IMM_LSB +: IMM_W]};

	// Immediate and memory forms take the immediate as second operand
	assign useImm = opcode == OP_ADDI || opcode == OP_MULI ||
		opcode == OP_DIVI || opcode == OP_LOAD || opcode == OP_STORE;

	// Stores read rd as data rather than writing it
	assign writesRd = opcode != OP_STORE;

	// Size comes from the suffix of the R3 opcode
	always_comb
	begin
		case (opcode)
		OP_R3B:  size = SZ_BYTE;
		OP_R3W:  size = SZ_WYDE;
		OP_R3T:  size = SZ_TETRA;
		// Octa register forms and all other opcodes work on 64 bits
		default: size = SZ_OCTA;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/decodeMerge.sv */
/*
	Merge stage of the decoder.
	Registers the classifier and operand decoder results into one decode
	record on each valid strobe. Adds exactly one cycle. Also works out the
	final register write enable, which is dropped for illegal micro-ops and
	for writes to r0.
*/

`timescale 1ns/100ps
`default_nettype none

module decodeMerge (
	input  wire logic                          clk,
	input  wire logic                          rst,
	input  wire logic                          instrValid,
	input  decodePkg::unit_e                   unit,
	input  wire logic                          illegal,
	input  wire logic [decodePkg::REG_W-1:0]   rd,
	input  wire logic [decodePkg::REG_W-1:0]   rs1,
	input  wire logic [decodePkg::REG_W-1:0]   rs2,
	input  wire logic [decodePkg::DATA_W-1:0]  imm,
	input  wire logic                          useImm,
	input  decodePkg::size_e                   size,
	input  wire logic                          writesRd,
	output logic                               outValid,
	output decodePkg::unit_e                   outUnit,
	output logic                               outIllegal,
	output logic [decodePkg::REG_W-1:0]        outRd,
	output logic [decodePkg::REG_W-1:0]        outRs1,
	output logic [decodePkg::REG_W-1:0]        outRs2,
	output logic [decodePkg::DATA_W-1:0]       outImm,
	output logic                               outUseImm,
	output decodePkg::size_e                   outSize,
	output logic                               regWrite
);

	import decodePkg::*;

	logic writeOk;

	// r0 is hardwired to zero so a write to it is dropped
	assign writeOk = writesRd && !illegal && rd != '0;

	// ==================================================
	// Control
	// ==================================================

	// Strobe and write enable follow the input every cycle
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			outValid <= 1'b0;
			regWrite <= 1'b0;
		end
		else
		begin
			outValid <= instrValid;
			regWrite <= instrValid && writeOk;
		end
	end

	// ==================================================
	// Decode record
	// ==================================================

	// Fields hold their last value between strobes
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			outUnit    <= UNIT_NONE;
			outIllegal <= 1'b0;
			outRd      <= '0;
			outRs1     <= '0;
			outRs2     <= '0;
			outImm     <= '0;
			outUseImm  <= 1'b0;
			outSize    <= SZ_BYTE;
		end
		else if (instrValid)
		begin
			outUnit    <= unit;
			outIllegal <= illegal;
			outRd      <= rd;
			outRs1     <= rs1;
			outRs2     <= rs2;
			outImm     <= imm;
			outUseImm  <= useImm;
			outSize    <= size;
		end
	end

endmodule

`default_nettype wire

/* verilog/decodeTop.sv */
/*
	Top level of the micro-op decode stage.
	Feeds one micro-op word to the unit classifier and the operand decoder
	in parallel, then registers both results in the merge stage. A record
	appears one cycle after its strobe.
*/

`timescale 1ns/100ps
`default_nettype none

module decodeTop (
	input  wire logic                          clk,
	input  wire logic                          rst,
	input  wire logic [decodePkg::INSTR_W-1:0] instr,
	input  wire logic                          instrValid,
	output logic                               outValid,
	output decodePkg::unit_e                   outUnit,
	output logic                               outIllegal,
	output logic [decodePkg::REG_W-1:0]        outRd,
	output logic [decodePkg::REG_W-1:0]        outRs1,
	output logic [decodePkg::REG_W-1:0]        outRs2,
	output logic [decodePkg::DATA_W-1:0]       outImm,
	output logic                               outUseImm,
	output decodePkg::size_e                   outSize,
	output logic                               regWrite
);

	import decodePkg::*;

	// Results of the two parallel decoders
	unit_e              unit;
	logic               illegal;
	logic [REG_W-1:0]   rd;
	logic [REG_W-1:0]   rs1;
	logic [REG_W-1:0]   rs2;
	logic [DATA_W-1:0]  imm;
	logic               useImm;
	size_e              size;
	logic               writesRd;

	decodeUnitClass unitClass_i (
		.instr   (instr),
		.unit    (unit),
		.illegal (illegal)
	);

	decodeOperands operands_i (
		.instr    (instr),
		.rd       (rd),
		.rs1      (rs1),
		.rs2      (rs2),
		.imm      (imm),
		.useImm   (useImm),
		.size     (size),
		.writesRd (writesRd)
	);

	decodeMerge merge_i (
		.clk        (clk),
		.rst        (rst),
		.instrValid (instrValid),
		.unit       (unit),
		.illegal    (illegal),
		.rd         (rd),
		.rs1        (rs1),
		.rs2        (rs2),
		.imm        (imm),
		.useImm     (useImm),
		.size       (size),
		.writesRd   (writesRd),
		.outValid   (outValid),
		.outUnit    (outUnit),
		.outIllegal (outIllegal),
		.outRd      (outRd),
		.outRs1     (outRs1),
		.outRs2     (outRs2),
		.outImm     (outImm),
		.outUseImm  (outUseImm),
		.outSize    (outSize),
		.regWrite   (regWrite)
	);

endmodule

`default_nettype wire

/* testbench/decodeMerge_assertions.sv */
/*
	Concurrent checks on the merge stage outputs.
	Bound into every decodeMerge instance. Covers the strobe after reset and
	the consistency between the write enable, rd and the illegal flag.
*/

`timescale 1ns/100ps
`default_nettype none

module decodeMergeAssertions (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  wire logic                        outValid,
	input  decodePkg::unit_e                 outUnit,
	input  wire logic                        outIllegal,
	input  wire logic [decodePkg::REG_W-1:0] outRd,
	input  wire logic                        regWrite
);

	import decodePkg::*;

	// The strobe is cleared on the edge where reset is seen
	validAfterReset: assert property (@(posedge clk) rst |=> !outValid)
		else $error("outValid high on the cycle after reset");

	// A write only goes out with a valid record
	writeNeedsValid: assert property (@(posedge clk) regWrite |-> outValid)
		else $error("regWrite high without outValid");

	// r0 is hardwired zero and never written
	writeNotR0: assert property (@(posedge clk) regWrite |-> outRd != '0)
		else $error("regWrite high with rd equal to r0");

	illegalHasNoUnit: assert property (@(posedge clk) outIllegal |-> outUnit == UNIT_NONE)
		else $error("illegal micro-op carries a functional unit");

endmodule

bind decodeMerge decodeMergeAssertions mergeChecks_i (
	.clk        (clk),
	.rst        (rst),
	.outValid   (outValid),
	.outUnit    (outUnit),
	.outIllegal (outIllegal),
	.outRd      (outRd),
	.regWrite   (regWrite)
);

`default_nettype wire

/* testbench/decodeTb.sv */
/*
	Testbench for the micro-op decode stage.
	Drives random micro-ops from an xorshift generator into the top level,
	keeps an expected decode record in a model built from the decode rules
	and compares every output one cycle after each strobe.
*/

`timescale 1ns/100ps
`default_nettype none

module decodeTb;

	import decodePkg::*;

	// ==================================================
	// Run length
	// ==================================================

	localparam int RESET_CYCLES = 3;
	localparam int NUM_CYCLES = 2000;
	// Reset plus every stimulus cycle, with some margin on top
	localparam int TIMEOUT_CYCLES = NUM_CYCLES + 100;

	logic                clk;
	logic                rst;
	logic [INSTR_W-1:0]  instr;
	logic                instrValid;
	logic                outValid;
	unit_e               outUnit;
	logic                outIllegal;
	logic [REG_W-1:0]    outRd;
	logic [REG_W-1:0]    outRs1;
	logic [REG_W-1:0]    outRs2;
	logic [DATA_W-1:0]   outImm;
	logic                outUseImm;
	size_e               outSize;
	logic                regWrite;

	// Expected record, held between strobes just like the DUT fields
	logic                expValid;
	logic [2:0]          expUnit;
	logic                expIllegal;
	logic [5:0]          expRd;
	logic [5:0]          expRs1;
	logic [5:0]          expRs2;
	logic [63:0]         expImm;
	logic                expUseImm;
	logic [1:0]          expSize;
	logic                expRegWrite;

	logic [31:0]         rngState;
	int                  cycleCount = 0;

	decodeTop dut_i (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.instrValid (instrValid),
		.outValid   (outValid),
		.outUnit    (outUnit),
		.outIllegal (outIllegal),
		.outRd      (outRd),
		.outRs1     (outRs1),
		.outRs2     (outRs2),
		.outImm     (outImm),
		.outUseImm  (outUseImm),
		.outSize    (outSize),
		.regWrite   (regWrite)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Stops a run that never reaches its end
	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TB FAILED");
			$fatal(1, "simulation stopped by the cycle limit");
		end
	end

	// ==================================================
	// Random stimulus
	// ==================================================

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Extra slots go to the register and divide forms, so every size sees divides
	function automatic logic [6:0] pickOpcode(input logic [3:0] sel);
		case (sel)
		4'd0:    pickOpcode = OP_R3B;
		4'd1:    pickOpcode = OP_R3W;
		4'd2:    pickOpcode = OP_R3T;
		4'd3:    pickOpcode = OP_R3O;
		4'd4:    pickOpcode = OP_R3P;
		4'd5:    pickOpcode = OP_ADDI;
		4'd6:    pickOpcode = OP_MULI;
		4'd7:    pickOpcode = OP_DIVI;
		4'd8:    pickOpcode = OP_LOAD;
		4'd9:    pickOpcode = OP_STORE;
		4'd10:   pickOpcode = OP_R3B;
		4'd11:   pickOpcode = OP_R3W;
		4'd12:   pickOpcode = OP_R3T;
		4'd13:   pickOpcode = OP_R3O;
		4'd14:   pickOpcode = OP_R3P;
		default: pickOpcode = OP_DIVI;
		endcase
	endfunction

	function automatic logic [6:0] pickFunc(input logic [2:0] sel);
		case (sel)
		3'd0:    pickFunc = FN_ADD;
		3'd1:    pickFunc = FN_SUB;
		3'd2:    pickFunc = FN_AND;
		3'd3:    pickFunc = FN_OR;
		3'd4:    pickFunc = FN_MUL;
		3'd5:    pickFunc = FN_DIV;
		3'd6:    pickFunc = FN_REM;
		default: pickFunc = FN_DIV;
		endcase
	endfunction

	// One draw steers the choices, a second one fills the raw word
	task automatic driveRandom();
		logic [31:0] ctrl;
		logic [31:0] word;
		rngState = xorshift(rngState);
		ctrl = rngState;
		rngState = xorshift(rngState);
		word = rngState;
		// Legal opcode and func 7 times in 8, otherwise any value
		if (ctrl[2:0] != 3'd0)
			word[6:0] = pickOpcode(ctrl[6:3]);
		else
			word[6:0] = ctrl[22:16];
		if (ctrl[9:7] != 3'd0)
			word[31:25] = pickFunc(ctrl[12:10]);
		else
			word[31:25] = ctrl[29:23];
		// Aim at r0 now and then so the dropped write gets exercised
		if (ctrl[15:13] == 3'd0)
			word[12:7] = 6'd0;
		instr = word;
		instrValid = ctrl[31:30] != 2'b00;
	endtask

	// ==================================================
	// Reference model
	// ==================================================

	function automatic logic [2:0] modelUnit(input logic [6:0] op, input logic [6:0] fn);
		logic isReg;
		isReg = op == OP_R3B || op == OP_R3W || op == OP_R3T || op == OP_R3O ||
			op == OP_R3P;
		modelUnit = UNIT_NONE;
		if (op == OP_DIVI)
			modelUnit = UNIT_DIV;
		else if (op == OP_MULI)
			modelUnit = UNIT_MUL;
		else if (op == OP_LOAD || op == OP_STORE)
			modelUnit = UNIT_MEM;
		else if (op == OP_ADDI)
			modelUnit = UNIT_ALU;
		else if (isReg)
		begin
			// Remainder is a divide as well
			case (fn)
			FN_DIV, FN_REM:                 modelUnit = UNIT_DIV;
			FN_MUL:                         modelUnit = UNIT_MUL;
			FN_ADD, FN_SUB, FN_AND, FN_OR:  modelUnit = UNIT_ALU;
			default:                        modelUnit = UNIT_NONE;
			endcase
		end
	endfunction

	// Works on the inputs that the DUT captured at the last edge
	task automatic applyModel();
		logic [6:0] op;
		op = instr[6:0];
		expValid = instrValid;
		expRegWrite = 1'b0;
		if (instrValid)
		begin
			expUnit = modelUnit(op, instr[31:25]);
			expIllegal = expUnit == UNIT_NONE;
			expRd = instr[12:7];
			expRs1 = instr[18:13];
			expRs2 = instr[24:19];
			expImm = {{51{instr[31]}}, instr[31:19]};
			expUseImm = op == OP_ADDI || op == OP_MULI || op == OP_DIVI ||
				op == OP_LOAD || op == OP_STORE;
			case (op)
			OP_R3B:  expSize = SZ_BYTE;
			OP_R3W:  expSize = SZ_WYDE;
			OP_R3T:  expSize = SZ_TETRA;
			default: expSize = SZ_OCTA;
			endcase
			// No write for stores, illegal micro-ops or r0
			expRegWrite = op != OP_STORE && !expIllegal && instr[12:7] != 6'd0;
		end
	endtask

	// ==================================================
	// Checks
	// ==================================================

	task automatic checkField(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected)
		else
		begin
			$display("ERROR %s at cycle %0d: expected %h, actual %h",
				name, cycleCount, expected, actual);
			$display("TB FAILED");
			$fatal(1, "stopping on the first mismatch");
		end
	endtask

	task automatic checkAll();
		checkField("strobe timing", 64'(expValid), 64'(outValid));
		checkField("unit class", 64'(expUnit), 64'(outUnit));
		checkField("illegal flag", 64'(expIllegal), 64'(outIllegal));
		checkField("rd field", 64'(expRd), 64'(outRd));
		checkField("rs1 field", 64'(expRs1), 64'(outRs1));
		checkField("rs2 field", 64'(expRs2), 64'(outRs2));
		checkField("immediate", expImm, outImm);
		checkField("use immediate", 64'(expUseImm), 64'(outUseImm));
		checkField("operand size", 64'(expSize), 64'(outSize));
		checkField("register write", 64'(expRegWrite), 64'(regWrite));
	endtask

	initial
	begin
		rst = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		rngState = 32'd39626;
		// Reset clears the whole record to zero
		expValid = 1'b0;
		expUnit = '0;
		expIllegal = 1'b0;
		expRd = '0;
		expRs1 = '0;
		expRs2 = '0;
		expImm = '0;
		expUseImm = 1'b0;
		expSize = '0;
		expRegWrite = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		checkAll();
		// Drive 1 ns after each edge and check 1 ns after the next one
		for (int i = 0; i < NUM_CYCLES; i++)
		begin
			driveRandom();
			@(posedge clk);
			#1;
			applyModel();
			checkAll();
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
verilog/decodePkg.sv
verilog/decodeUnitClass.sv
verilog/decodeOperands.sv
verilog/decodeMerge.sv
verilog/decodeTop.sv
testbench/decodeMerge_assertions.sv
testbench/decodeTb.sv

/* run.sh */
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module decodeTb \
	-f compile.f

./obj_dir/VdecodeTb
